/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   //////////////////////////////////////////////////
   // widths and sizes

   localparam int CODE_ADDR_W = 10;
   localparam int CODE_BYTES  = 32;   // bytes taken by the serial loader

   typedef logic [CODE_ADDR_W-1:0] code_addr_t;
   typedef logic [7:0]             byte_t;
   typedef logic [1:0]             op_len_t;   // 1..3 bytes

   typedef enum logic [2:0] {
      ST_LOAD    = 3'd0,
      ST_FETCH   = 3'd1,
      ST_DECODE0 = 3'd2,
      ST_DECODE1 = 3'd3,
      ST_DECODE2 = 3'd4,
      ST_EXECUTE = 3'd5
   } cpu_state_e;

   //////////////////////////////////////////////////
   // opcodes, standard 8051 encoding

   localparam byte_t OP_NOP         = 8'h00;
   localparam byte_t OP_LJMP        = 8'h02;   // ljmp addr16
   localparam byte_t OP_INC_A       = 8'h04;
   localparam byte_t OP_DEC_A       = 8'h14;
   localparam byte_t OP_ADD_A_IMM   = 8'h24;
   localparam byte_t OP_ORL_A_IMM   = 8'h44;
   localparam byte_t OP_ANL_A_IMM   = 8'h54;
   localparam byte_t OP_JZ          = 8'h60;
   localparam byte_t OP_XRL_A_IMM   = 8'h64;
   localparam byte_t OP_JNZ         = 8'h70;
   localparam byte_t OP_MOV_A_IMM   = 8'h74;
   localparam byte_t OP_SJMP        = 8'h80;
   localparam byte_t OP_MOV_DPTR    = 8'h90;   // mov dptr, #imm16
   localparam byte_t OP_CLR_A       = 8'hE4;
   localparam byte_t OP_MOVX_DPTR_A = 8'hF0;
   localparam byte_t OP_CPL_A       = 8'hF4;

   localparam logic [15:0] TX_DPTR = 16'h0201;   // movx here starts a transmission

endpackage

`default_nettype wire

/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

   localparam int BIT_CYCLES = 104;   // clocks per bit
   localparam int HALF_BIT   = 52;

   typedef logic [6:0] bit_cnt_t;

   localparam logic LINE_IDLE = 1'b1;   // mark level, also the stop bit

endpackage

`default_nettype wire

/* source/uart_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface uart_if ();
   import cpu_pkg::*;

   logic  rx_valid;   // one cycle per received byte
   byte_t rx_byte;
   logic  tx_start;   // only while tx_busy is low
   byte_t tx_byte;
   logic  tx_busy;

   modport rx_side (output rx_valid, output rx_byte);
   modport loader  (input rx_valid, input rx_byte);
   modport tx_side (input tx_start, input tx_byte, output tx_busy);
   modport core    (output tx_start, output tx_byte, input tx_busy);

endinterface

`default_nettype wire

/* source/uart_baud_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_baud_timer (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_restart,
   output logic o_half,
   output logic o_full
);
   import uart_pkg::*;

   bit_cnt_t cnt_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         cnt_q <= '0;
      else if (i_restart || o_full)   // wrap at end of each period
         cnt_q <= '0;
      else
         cnt_q <= cnt_q + 1'b1;
   end

   assign o_half = (cnt_q == bit_cnt_t'(HALF_BIT - 1));
   assign o_full = (cnt_q == bit_cnt_t'(BIT_CYCLES - 1));

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
   input  logic    i_clk,
   input  logic    i_nrst,
   input  logic    i_uart_rx,
   uart_if.rx_side rx
);
   import uart_pkg::*;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e  state_q;
   logic [2:0] sync_q;
   logic [2:0] bit_idx_q;
   logic [7:0] shift_q;
   logic       valid_q;
   logic       line;
   logic       start_edge;
   logic       restart;
   logic       half;
   logic       full;

   uart_baud_timer u_timer (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_restart (restart),
      .o_half    (half),
      .o_full    (full)
   );

   // two flops against metastability, third one for the edge
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         sync_q <= {3{LINE_IDLE}};
      else
         sync_q <= {sync_q[1:0], i_uart_rx};
   end

   assign line       = sync_q[1];
   assign start_edge = (sync_q[2] == LINE_IDLE) && (sync_q[1] != LINE_IDLE);
   assign restart    = (state_q == RX_IDLE) || ((state_q == RX_START) && half);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q   <= RX_IDLE;
         bit_idx_q <= '0;
      end else begin
         case (state_q)
            RX_IDLE: begin
               bit_idx_q <= '0;
               if (start_edge) state_q <= RX_START;
            end
            RX_START: begin   // mid start bit, glitch check
               if (half) begin
                  if (line == LINE_IDLE) state_q <= RX_IDLE;
                  else                   state_q <= RX_DATA;
               end
            end
            RX_DATA: begin
               if (full) begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7) state_q <= RX_STOP;
               end
            end
            RX_STOP: if (full) state_q <= RX_IDLE;
            default: state_q <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if ((state_q == RX_DATA) && full)
         shift_q <= {line, shift_q[7:1]};   // lsb arrives first
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) valid_q <= 1'b0;
      else         valid_q <= (state_q == RX_STOP) && full;
   end

   assign rx.rx_valid = valid_q;
   assign rx.rx_byte  = shift_q;

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
   input  logic    i_clk,
   input  logic    i_nrst,
   uart_if.tx_side tx,
   output logic    o_uart_tx
);
   import uart_pkg::*;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e  state_q;
   logic [7:0] shift_q;
   logic [3:0] bit_idx_q;   // 0..7 data, 8 stop
   logic       full;

   uart_baud_timer u_timer (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_restart (state_q == TX_IDLE),
      .o_half    (),                    // no centering needed on the send side
      .o_full    (full)
   );

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_q   <= TX_IDLE;
         bit_idx_q <= '0;
      end else begin
         case (state_q)
            TX_IDLE:  if (tx.tx_start) state_q <= TX_START;
            TX_START: begin
               bit_idx_q <= '0;
               if (full) state_q <= TX_SEND;
            end
            TX_SEND: begin
               if (full) begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 4'd8) state_q <= TX_IDLE;   // stop bit done
               end
            end
            default: state_q <= TX_IDLE;
         endcase
      end
   end

   // refill with idle level so the stop bit falls out after the data
   always_ff @(posedge i_clk) begin
      if ((state_q == TX_IDLE) && tx.tx_start)
         shift_q <= tx.tx_byte;
      else if ((state_q == TX_SEND) && full)
         shift_q <= {LINE_IDLE, shift_q[7:1]};
   end

   always_comb begin
      case (state_q)
         TX_START: o_uart_tx = ~LINE_IDLE;
         TX_SEND:  o_uart_tx = shift_q[0];
         default:  o_uart_tx = LINE_IDLE;
      endcase
   end

   assign tx.tx_busy = (state_q != TX_IDLE);

endmodule

`default_nettype wire

/* source/cpu_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_sequencer (
   input  logic                i_clk,
   input  logic                i_nrst,
   uart_if.loader              ld,
   input  cpu_pkg::op_len_t    i_op_len,
   input  logic                i_exec_hold,
   input  cpu_pkg::code_addr_t i_pc,
   output cpu_pkg::cpu_state_e o_state,
   output logic                o_code_wr,
   output cpu_pkg::code_addr_t o_code_addr,
   output cpu_pkg::byte_t      o_code_data
);
   import cpu_pkg::*;

   cpu_state_e state_q;
   cpu_state_e state_d;
   code_addr_t load_addr_q;
   logic       load_last;

   //////////////////////////////////////////////////
   // serial load phase

   assign o_code_wr = (state_q == ST_LOAD) && ld.rx_valid;   // every byte goes straight in
   assign load_last = o_code_wr && (load_addr_q == code_addr_t'(CODE_BYTES - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)        load_addr_q <= '0;
      else if (o_code_wr) load_addr_q <= load_addr_q + 1'b1;
   end

   //////////////////////////////////////////////////
   // fetch / decode / execute

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_LOAD:    if (load_last) state_d = ST_FETCH;
         ST_FETCH:   state_d = ST_DECODE0;
         ST_DECODE0: begin
            if (i_op_len == 2'd1) state_d = ST_EXECUTE;
            else                  state_d = ST_DECODE1;
         end
         ST_DECODE1: begin
            if (i_op_len == 2'd3) state_d = ST_DECODE2;
            else                  state_d = ST_EXECUTE;
         end
         ST_DECODE2: state_d = ST_EXECUTE;
         ST_EXECUTE: if (!i_exec_hold) state_d = ST_FETCH;   // movx stall
         default:    state_d = ST_LOAD;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state_q <= ST_LOAD;
      else         state_q <= state_d;
   end

   assign o_state     = state_q;
   assign o_code_addr = (state_q == ST_LOAD) ? load_addr_q : i_pc;
   assign o_code_data = ld.rx_byte;

endmodule

`default_nettype wire

/* source/cpu_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_datapath (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  cpu_pkg::cpu_state_e i_state,
   input  cpu_pkg::byte_t      i_code_data,
   output cpu_pkg::op_len_t    o_op_len,
   output logic                o_exec_hold,
   output cpu_pkg::code_addr_t o_pc,
   uart_if.core                core
);
   import cpu_pkg::*;

   byte_t       op_q;
   byte_t       opr1_q;   // first operand as imm8 or rel or high byte
   byte_t       opr2_q;
   byte_t       op;
   byte_t       acc_q;
   byte_t       acc_d;
   logic [15:0] dptr_q;
   logic [15:0] imm16;
   code_addr_t  pc_q;
   code_addr_t  pc_d;
   code_addr_t  rel_target;
   logic        acc_zero;
   logic        take_rel;
   logic        movx_tx;

   //////////////////////////////////////////////////
   // opcode and operand latches

   always_ff @(posedge i_clk) begin
      if (i_state == ST_DECODE0) op_q   <= i_code_data;
      if (i_state == ST_DECODE1) opr1_q <= i_code_data;
      if (i_state == ST_DECODE2) opr2_q <= i_code_data;
   end

   assign op    = (i_state == ST_DECODE0) ? i_code_data : op_q;   // live in decode0
   assign imm16 = {opr1_q, opr2_q};

   always_comb begin
      case (op)
         OP_MOV_A_IMM, OP_ADD_A_IMM, OP_ANL_A_IMM, OP_ORL_A_IMM, OP_XRL_A_IMM,
         OP_SJMP, OP_JZ, OP_JNZ:
            o_op_len = 2'd2;
         OP_MOV_DPTR, OP_LJMP:
            o_op_len = 2'd3;
         default:
            o_op_len = 2'd1;   // one-byte opcodes and unknown ones
      endcase
   end

   //////////////////////////////////////////////////
   // accumulator and dptr

   always_comb begin
      acc_d = acc_q;
      case (op_q)
         OP_MOV_A_IMM: acc_d = opr1_q;
         OP_ADD_A_IMM: acc_d = acc_q + opr1_q;   // carry dropped
         OP_ANL_A_IMM: acc_d = acc_q & opr1_q;
         OP_ORL_A_IMM: acc_d = acc_q | opr1_q;
         OP_XRL_A_IMM: acc_d = acc_q ^ opr1_q;
         OP_INC_A:     acc_d = acc_q + 1'b1;
         OP_DEC_A:     acc_d = acc_q - 1'b1;
         OP_CLR_A:     acc_d = '0;
         OP_CPL_A:     acc_d = ~acc_q;
         default:      ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         acc_q <= '0;
      else if (i_state == ST_EXECUTE)
         acc_q <= acc_d;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         dptr_q <= '0;
      else if ((i_state == ST_EXECUTE) && (op_q == OP_MOV_DPTR))
         dptr_q <= imm16;
   end

   //////////////////////////////////////////////////
   // program counter

   assign acc_zero   = (acc_q == '0);
   assign take_rel   = (op_q == OP_SJMP) || ((op_q == OP_JZ) && acc_zero) ||
                       ((op_q == OP_JNZ) && !acc_zero);
   assign rel_target = pc_q + {{(CODE_ADDR_W-8){opr1_q[7]}}, opr1_q};   // pc is past the jump

   always_comb begin
      pc_d = pc_q;
      case (i_state)
         ST_FETCH:   pc_d = pc_q + 1'b1;
         ST_DECODE0: if (o_op_len != 2'd1) pc_d = pc_q + 1'b1;
         ST_DECODE1: if (o_op_len == 2'd3) pc_d = pc_q + 1'b1;
         ST_EXECUTE: begin
            if (op_q == OP_LJMP) pc_d = imm16[CODE_ADDR_W-1:0];
            else if (take_rel)   pc_d = rel_target;
         end
         default:    ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc_q <= '0;
      else         pc_q <= pc_d;
   end

   assign o_pc = pc_q;

   // movx to the transmit address waits while the uart is sending
   assign movx_tx       = (i_state == ST_EXECUTE) && (op_q == OP_MOVX_DPTR_A) &&
                          (dptr_q == TX_DPTR);
   assign core.tx_start = movx_tx && !core.tx_busy;
   assign core.tx_byte  = acc_q;
   assign o_exec_hold   = movx_tx && core.tx_busy;

endmodule

`default_nettype wire

/* source/ice51_lite.sv */
`timescale 1ns/10ps
`default_nettype none

module ice51_lite (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic       o_uart_tx,
   output logic       o_code_wr,
   output logic [9:0] o_code_addr,
   output logic [7:0] o_code_data,
   input  logic [7:0] i_code_data
);
   import cpu_pkg::*;

   cpu_state_e state;
   op_len_t    op_len;
   logic       exec_hold;
   code_addr_t pc;

   uart_if uart_bus ();

   uart_rx u_uart_rx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .rx        (uart_bus.rx_side)
   );

   uart_tx u_uart_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .tx        (uart_bus.tx_side),
      .o_uart_tx (o_uart_tx)
   );

   cpu_sequencer u_sequencer (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .ld          (uart_bus.loader),
      .i_op_len    (op_len),
      .i_exec_hold (exec_hold),
      .i_pc        (pc),
      .o_state     (state),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_code_data (o_code_data)
   );

   cpu_datapath u_datapath (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_state     (state),
      .i_code_data (i_code_data),
      .o_op_len    (op_len),
      .o_exec_hold (exec_hold),
      .o_pc        (pc),
      .core        (uart_bus.core)
   );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic o_clk
);

   localparam int HALF_PERIOD_NS = 4;   // 8 ns period

   initial begin
      o_clk = 1'b0;
      forever #HALF_PERIOD_NS o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

/* testbench/ice51_lite_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module ice51_lite_asserts (
   input logic                i_clk,
   input logic                i_nrst,
   input cpu_pkg::cpu_state_e i_state,
   input logic                i_uart_tx,
   input logic                i_code_wr
);
   import cpu_pkg::*;
   import uart_pkg::*;

   localparam int FRAME_CYCLES = 10 * BIT_CYCLES;

   logic [10:0] frame_left_q;   // cycles left in the current frame
   int          fail_cnt = 0;

   // frame tracker, armed by the first low cycle on an idle line
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         frame_left_q <= '0;
      else if (frame_left_q != '0)
         frame_left_q <= frame_left_q - 1'b1;
      else if (i_uart_tx != LINE_IDLE)
         frame_left_q <= 11'(FRAME_CYCLES - 1);
   end

   write_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_code_wr |=> !i_code_wr)
      else begin
         fail_cnt++;
         $error("code write pulse lasted more than one cycle");
      end

   idle_while_loading: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_state == ST_LOAD) |-> (i_uart_tx == LINE_IDLE))
      else begin
         fail_cnt++;
         $error("serial output left idle before the program ran");
      end

   start_bit_low: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (frame_left_q > 11'(9 * BIT_CYCLES)) |-> (i_uart_tx != LINE_IDLE))
      else begin
         fail_cnt++;
         $error("start bit shorter than one bit period");
      end

   stop_bit_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      ((frame_left_q != '0) && (frame_left_q <= 11'(BIT_CYCLES))) |->
      (i_uart_tx == LINE_IDLE))
      else begin
         fail_cnt++;
         $error("stop bit not high for a full bit period");
      end

endmodule

bind ice51_lite ice51_lite_asserts u_asserts (
   .i_clk     (i_clk),
   .i_nrst    (i_nrst),
   .i_state   (state),
   .i_uart_tx (o_uart_tx),
   .i_code_wr (o_code_wr)
);

`default_nettype wire

/* testbench/tb_ice51_lite.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ice51_lite;
   import cpu_pkg::*;
   import uart_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
   localparam int IDLE_CHECK   = 2 * FRAME_CYCLES;
   // load of about 34,000 clocks with gaps plus five frames and the idle check
   localparam int TIMEOUT_CYCLES = 50000;

   localparam byte_t IMM_MOV    = 8'h5A;
   localparam byte_t IMM_ADD    = 8'h13;
   localparam byte_t IMM_XRL    = 8'h0F;
   localparam byte_t LOOP_START = 8'd3;
   localparam byte_t IMM_ORL    = 8'h30;
   localparam byte_t IMM_ANL    = 8'h3E;
   localparam byte_t STRAY_BYTE = 8'hA5;   // sent after the load, never written

   logic       clk;
   logic       nrst;
   logic       uart_rx;
   logic       uart_tx;
   logic       code_wr;
   logic [9:0] code_addr;
   logic [7:0] code_wdata;
   logic [7:0] code_rdata;

   byte_t      prog [CODE_BYTES];
   byte_t      mem  [CODE_BYTES];   // external code memory model
   code_addr_t rd_addr;
   byte_t      exp_q [$];
   integer     seed;
   int         fill_idx;
   int         n_expected;
   int         load_count = 0;
   int         rx_count   = 0;
   int         load_errs  = 0;
   int         tx_errs    = 0;
   int         idle_errs  = 0;
   int         cycle_cnt  = 0;

   tb_clock_gen u_clk (.o_clk(clk));

   ice51_lite u_dut (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_uart_rx   (uart_rx),
      .o_uart_tx   (uart_tx),
      .o_code_wr   (code_wr),
      .o_code_addr (code_addr),
      .o_code_data (code_wdata),
      .i_code_data (code_rdata)
   );

   //////////////////////////////////////////////////
   // program and expected serial output

   task automatic place_code_byte(input byte_t b);
      prog[fill_idx] = b;
      fill_idx++;
   endtask

   task automatic build_program();
      int loop_addr;
      int park_addr;
      for (int i = 0; i < CODE_BYTES; i++)
         prog[i] = OP_NOP;
      fill_idx = 0;
      place_code_byte(OP_MOV_DPTR);
      place_code_byte(TX_DPTR[15:8]);
      place_code_byte(TX_DPTR[7:0]);
      place_code_byte(OP_MOV_A_IMM);
      place_code_byte(IMM_MOV);
      place_code_byte(OP_ADD_A_IMM);
      place_code_byte(IMM_ADD);
      place_code_byte(OP_XRL_A_IMM);
      place_code_byte(IMM_XRL);
      place_code_byte(OP_MOVX_DPTR_A);
      place_code_byte(OP_MOV_A_IMM);
      place_code_byte(LOOP_START);
      loop_addr = fill_idx;
      place_code_byte(OP_MOVX_DPTR_A);
      place_code_byte(OP_DEC_A);
      place_code_byte(OP_JNZ);
      place_code_byte(byte_t'(loop_addr - (fill_idx + 1)));   // rel from next instr
      place_code_byte(OP_INC_A);
      place_code_byte(OP_ORL_A_IMM);
      place_code_byte(IMM_ORL);
      place_code_byte(OP_ANL_A_IMM);
      place_code_byte(IMM_ANL);
      place_code_byte(OP_CPL_A);
      place_code_byte(OP_MOVX_DPTR_A);
      park_addr = fill_idx;
      place_code_byte(OP_SJMP);
      place_code_byte(byte_t'(park_addr - (fill_idx + 1)));   // jump to itself
   endtask

   task automatic build_expected();
      byte_t acc;
      acc = IMM_MOV;
      acc = acc + IMM_ADD;   // carry is lost
      acc = acc ^ IMM_XRL;
      exp_q.push_back(acc);
      for (int v = LOOP_START; v > 0; v--)
         exp_q.push_back(byte_t'(v));
      acc = 8'h00;   // loop exits at zero
      acc = acc + 8'h01;
      acc = acc | IMM_ORL;
      acc = acc & IMM_ANL;
      acc = ~acc;
      exp_q.push_back(acc);
   endtask

   //////////////////////////////////////////////////
   // serial driver and monitor

   task automatic send_frame(input byte_t b);
      int gap;
      uart_rx = ~LINE_IDLE;   // start bit
      repeat (BIT_CYCLES) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         uart_rx = b[i];
         repeat (BIT_CYCLES) @(negedge clk);
      end
      uart_rx = LINE_IDLE;
      repeat (BIT_CYCLES) @(negedge clk);
      gap = 1 + ({$random(seed)} % 64);
      repeat (gap) @(negedge clk);
   endtask

   task automatic read_frame(output byte_t b);
      repeat (HALF_BIT - 1) @(negedge clk);   // to the middle of the start bit
      assert (uart_tx == ~LINE_IDLE) else begin
         tx_errs++;
         $display("FAIL @%0t: start bit ended before its middle", $time);
      end
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(negedge clk);
         b[i] = uart_tx;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      assert (uart_tx == LINE_IDLE) else begin
         tx_errs++;
         $display("FAIL @%0t: stop bit low", $time);
      end
   endtask

   task automatic check_tx_byte(input byte_t b);
      byte_t exp;
      rx_count++;
      assert (exp_q.size() > 0) else begin
         tx_errs++;
         $display("FAIL @%0t: extra byte %02h after the last expected one", $time, b);
      end
      if (exp_q.size() > 0) begin
         exp = exp_q.pop_front();
         assert (b == exp) else begin
            tx_errs++;
            $display("FAIL @%0t: sent byte %02h, expected %02h", $time, b, exp);
         end
      end
   endtask

   initial begin
      byte_t got;
      wait (nrst === 1'b1);
      forever begin
         @(negedge clk);
         if (uart_tx == ~LINE_IDLE) begin
            read_frame(got);
            check_tx_byte(got);
         end
      end
   end

   //////////////////////////////////////////////////
   // code memory, one cycle read latency

   always @(negedge clk) begin
      if (rd_addr < CODE_BYTES)
         code_rdata = mem[rd_addr];
      else
         code_rdata = OP_NOP;
      rd_addr = code_addr;   // address seen by the next rising edge
      if (code_wr && (code_addr < CODE_BYTES))
         mem[code_addr] = code_wdata;
   end

   always @(negedge clk) begin
      if (nrst && code_wr) begin
         assert (load_count < CODE_BYTES) else begin
            load_errs++;
            $display("FAIL @%0t: code write to %0d after the load ended", $time, code_addr);
         end
         if (load_count < CODE_BYTES) begin
            assert (code_addr == load_count) else begin
               load_errs++;
               $display("FAIL @%0t: load address %0d, expected %0d", $time, code_addr,
                        load_count);
            end
            assert (code_wdata == prog[load_count]) else begin
               load_errs++;
               $display("FAIL @%0t: load data %02h, expected %02h", $time, code_wdata,
                        prog[load_count]);
            end
         end
         load_count++;
      end
   end

   //////////////////////////////////////////////////
   // run control

   task automatic report_and_finish(input bit timed_out);
      int total;
      total = load_errs + tx_errs + idle_errs + u_dut.u_asserts.fail_cnt;
      $display("errors: %0d load, %0d serial, %0d idle, %0d assertion; %0d of %0d bytes",
               load_errs, tx_errs, idle_errs, u_dut.u_asserts.fail_cnt, rx_count, n_expected);
      if (!timed_out && (total == 0)) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         report_and_finish(1'b1);
      end
   end

   initial begin
      bit idle_ok;
      int n;
      seed       = 32'h30470756;
      nrst       = 1'b0;
      uart_rx    = LINE_IDLE;
      code_rdata = OP_NOP;
      rd_addr    = '0;
      build_program();
      build_expected();
      n_expected = exp_q.size();
      repeat (RESET_CYCLES) @(negedge clk);
      nrst = 1'b1;
      repeat (16) @(negedge clk);
      for (int i = 0; i < CODE_BYTES; i++)
         send_frame(prog[i]);
      send_frame(STRAY_BYTE);   // arrives while the program runs
      while (rx_count < n_expected)
         @(negedge clk);
      // parked in sjmp so nothing more may go out
      idle_ok = 1'b1;
      n = 0;
      while (idle_ok && (n < IDLE_CHECK)) begin
         @(negedge clk);
         assert (uart_tx == LINE_IDLE) else begin
            idle_ok = 1'b0;
            idle_errs++;
            $display("FAIL @%0t: serial line active after the last byte", $time);
         end
         n++;
      end
      report_and_finish(1'b0);
   end

endmodule

`default_nettype wire

/* ice51_lite.f */
source/cpu_pkg.sv
source/uart_pkg.sv
source/uart_if.sv
source/uart_baud_timer.sv
source/uart_rx.sv
source/uart_tx.sv
source/cpu_sequencer.sv
source/cpu_datapath.sv
source/ice51_lite.sv
testbench/tb_clock_gen.sv
testbench/ice51_lite_asserts.sv
testbench/tb_ice51_lite.sv

/* Bender.yml */
package:
  name: ice51_lite

sources:
  - source/cpu_pkg.sv
  - source/uart_pkg.sv
  - source/uart_if.sv
  - source/uart_baud_timer.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/cpu_sequencer.sv
  - source/cpu_datapath.sv
  - source/ice51_lite.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/ice51_lite_asserts.sv
      - testbench/tb_ice51_lite.sv
